// ==== flist.f ====
hw/wb_bus_pkg.sv
hw/soc_map_pkg.sv
hw/wb_req_if.sv
hw/wb_addr_decode.sv
hw/dma_copy_engine.sv
hw/mem_arbiter.sv
hw/wb_sram.sv
hw/wb_dma_subsystem.sv
tb/tb_wb_dma_subsystem.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -j 0 \
    -f flist.f --top-module tb_wb_dma_subsystem -o sim_tb
status=$?
if [ $status -ne 0 ]; then
    echo "Build failed with status $status"
    exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -F -q '*** TEST FAILED ***' sim.log; then
    echo "Simulation reported failure"
    exit 1
fi

echo "Simulation reported no failure"
exit 0

// ==== tb/tb_wb_dma_subsystem.sv ====
// Subsystem testbench
`timescale 1ns/1ps
`default_nettype none

module tb_wb_dma_subsystem;

    import soc_map_pkg::*;

    localparam int unsigned MEM_WORDS = 4096;
    localparam int unsigned LEN_W     = 16;

    // Cycle estimates per test, an access costs about 4 and a copied word about 12
    localparam int RESET_CYC    = 20;
    localparam int MEM_CYC      = 64 * 4;
    localparam int UNMAP_CYC    = 4 * 4;
    localparam int COPY_CYC     = 16 * 4 + 16 * 12 + 16 * 4 + 20;
    localparam int CONTEND_CYC  = 32 * 4 + 16 * 8 + 32 * 12 + 32 * 4 + 20;
    localparam int REGS_CYC     = 12 * 4 + 12 * 12 + 12 * 4 + 60;
    localparam int WATCHDOG_CYC =
        4 * (RESET_CYC + MEM_CYC + UNMAP_CYC + COPY_CYC + CONTEND_CYC + REGS_CYC);

    logic        clk;
    logic        rst;
    logic        wbs_stb_i;
    logic        wbs_cyc_i;
    logic        wbs_we_i;
    logic [3:0]  wbs_sel_i;
    logic [31:0] wbs_adr_i;
    logic [31:0] wbs_dat_i;
    logic        wbs_ack_o;
    logic [31:0] wbs_dat_o;
    logic        dma_busy_o;

    // Expected memory contents, indexed by word
    logic [31:0] ref_mem [MEM_WORDS];
    int          errors;
    int          err_mark;
    int          tests_ok;
    int          tests_bad;
    int          last_lat;
    string       cur_test;

    wb_dma_subsystem #(
        .MEM_WORDS (MEM_WORDS),
        .LEN_W     (LEN_W)
    ) dut_i (
        .clk        (clk),
        .rst        (rst),
        .wbs_stb_i  (wbs_stb_i),
        .wbs_cyc_i  (wbs_cyc_i),
        .wbs_we_i   (wbs_we_i),
        .wbs_sel_i  (wbs_sel_i),
        .wbs_adr_i  (wbs_adr_i),
        .wbs_dat_i  (wbs_dat_i),
        .wbs_ack_o  (wbs_ack_o),
        .wbs_dat_o  (wbs_dat_o),
        .dma_busy_o (dma_busy_o)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    function automatic logic [31:0] word_addr(input int w);
        return MEM_BASE + 32'(w * 4);
    endfunction

    // Byte lanes with sel set take the new data
    function automatic logic [31:0] merge_bytes(input logic [31:0] old_w,
                                                input logic [31:0] new_w,
                                                input logic [3:0] sel);
        logic [31:0] res;
        res = old_w;
        for (int b = 0; b < 4; b++) begin
            if (sel[b]) begin
                res[8*b +: 8] = new_w[8*b +: 8];
            end
        end
        return res;
    endfunction

    task automatic check_value(input logic [31:0] exp, input logic [31:0] act);
        assert (act === exp) else begin
            $display("[FAIL] %s expected %h actual %h", cur_test, exp, act);
            errors++;
        end
    endtask

    task automatic check_true(input logic cond, input string msg);
        assert (cond === 1'b1) else begin
            $display("Error in %s: %s", cur_test, msg);
            errors++;
        end
    endtask

    // One bus cycle, strobe held until ack, latency counted from the strobe cycle
    task automatic do_access(input logic we, input logic [3:0] sel, input logic [31:0] adr,
                             input logic [31:0] wdat, output logic [31:0] rdat);
        int edges;
        @(posedge clk);
        wbs_stb_i <= 1'b1;
        wbs_cyc_i <= 1'b1;
        wbs_we_i  <= we;
        wbs_sel_i <= sel;
        wbs_adr_i <= adr;
        wbs_dat_i <= wdat;
        edges = 0;
        do begin
            @(posedge clk);
            edges++;
        end while (wbs_ack_o !== 1'b1);
        rdat     = wbs_dat_o;
        last_lat = edges - 1;
        wbs_stb_i <= 1'b0;
        wbs_cyc_i <= 1'b0;
        wbs_we_i  <= 1'b0;
    endtask

    task automatic write_word(input logic [31:0] adr, input logic [31:0] d,
                              input logic [3:0] sel);
        logic [31:0] unused;
        do_access(1'b1, sel, adr, d, unused);
    endtask

    task automatic read_word(input logic [31:0] adr, output logic [31:0] d);
        do_access(1'b0, 4'hf, adr, 32'h0, d);
    endtask

    task automatic fill_words(input int first, input int count);
        logic [31:0] d;
        for (int i = first; i < first + count; i++) begin
            d = $urandom;
            write_word(word_addr(i), d, 4'hf);
            ref_mem[i] = d;
            check_true(last_lat >= 2, "memory write acknowledged within one cycle");
        end
    endtask

    task automatic verify_words(input int first, input int count);
        logic [31:0] d;
        for (int i = first; i < first + count; i++) begin
            read_word(word_addr(i), d);
            check_value(ref_mem[i], d);
            check_true(last_lat >= 2, "memory read acknowledged within one cycle");
        end
    endtask

    task automatic start_copy(input int src, input int dst, input int count);
        write_word(DMA_BASE + DMA_REG_SRC, word_addr(src), 4'hf);
        write_word(DMA_BASE + DMA_REG_DST, word_addr(dst), 4'hf);
        write_word(DMA_BASE + DMA_REG_CTRL, 32'(count), 4'hf);
        check_true(dma_busy_o, "dma_busy_o did not rise after the copy was started");
        for (int i = 0; i < count; i++) begin
            ref_mem[dst + i] = ref_mem[src + i];
        end
    endtask

    task automatic wait_dma_idle(input int words);
        int bound;
        int n;
        bound = words * 12 + 20;
        n = 0;
        while (dma_busy_o === 1'b1 && n < bound) begin
            @(posedge clk);
            n++;
        end
        check_true(dma_busy_o === 1'b0,
                   $sformatf("copy of %0d words still busy after %0d cycles", words, bound));
    endtask

    task automatic begin_test(input string name);
        cur_test = name;
        err_mark = errors;
    endtask

    task automatic end_test();
        if (errors == err_mark) begin
            tests_ok++;
            $display("Test %s: ok", cur_test);
        end else begin
            tests_bad++;
            $display("Test %s: %0d errors", cur_test, errors - err_mark);
        end
    endtask

    initial begin
        int          w;
        logic [3:0]  sel;
        logic [31:0] d;
        logic [31:0] rdata;
        logic [31:0] s1;
        logic [31:0] s2;
        void'($urandom(32'hc9108d0a));
        rst       = 1'b1;
        wbs_stb_i = 1'b0;
        wbs_cyc_i = 1'b0;
        wbs_we_i  = 1'b0;
        wbs_sel_i = 4'h0;
        wbs_adr_i = 32'h0;
        wbs_dat_i = 32'h0;
        errors    = 0;
        tests_ok  = 0;
        tests_bad = 0;
        repeat (2) @(posedge clk);
        rst <= 1'b0;

        begin_test("reset");
        @(posedge clk);
        check_true(wbs_ack_o === 1'b0, "wbs_ack_o is not low after reset");
        check_true(dma_busy_o === 1'b0, "dma_busy_o is not low after reset");
        read_word(DMA_BASE + DMA_REG_STAT, rdata);
        check_value(32'h0, rdata);
        end_test();

        begin_test("memory");
        fill_words(0, 16);
        for (int i = 0; i < 32; i++) begin
            w   = $urandom_range(15, 0);
            sel = 4'($urandom_range(15, 1));
            d   = $urandom;
            write_word(word_addr(w), d, sel);
            ref_mem[w] = merge_bytes(ref_mem[w], d, sel);
            check_true(last_lat >= 2, "memory write acknowledged within one cycle");
        end
        verify_words(0, 16);
        end_test();

        begin_test("unmapped");
        read_word(32'h2000_0000, rdata);
        check_value(32'h0, rdata);
        read_word(MEM_BASE + MEM_SPAN, rdata);
        check_value(32'h0, rdata);
        write_word(DMA_BASE + 32'h10, $urandom, 4'hf);
        read_word(DMA_BASE + 32'h10, rdata);
        check_value(32'h0, rdata);
        end_test();

        begin_test("dma_copy");
        fill_words(64, 16);
        start_copy(64, 128, 16);
        wait_dma_idle(16);
        verify_words(128, 16);
        end_test();

        // CPU traffic to words the copy never touches
        begin_test("contention");
        fill_words(192, 32);
        start_copy(192, 256, 32);
        for (int i = 0; i < 8; i++) begin
            d = $urandom;
            write_word(word_addr(512 + i), d, 4'hf);
            ref_mem[512 + i] = d;
            read_word(word_addr(512 + i), rdata);
            check_value(d, rdata);
        end
        check_true(dma_busy_o, "the copy ended before the CPU accesses finished");
        wait_dma_idle(32);
        verify_words(256, 32);
        end_test();

        begin_test("registers");
        d = $urandom;
        write_word(DMA_BASE + DMA_REG_SRC, d, 4'hf);
        read_word(DMA_BASE + DMA_REG_SRC, rdata);
        check_value(d, rdata);
        d = $urandom;
        write_word(DMA_BASE + DMA_REG_DST, d, 4'hf);
        read_word(DMA_BASE + DMA_REG_DST, rdata);
        check_value(d, rdata);
        fill_words(600, 12);
        start_copy(600, 700, 12);
        read_word(DMA_BASE + DMA_REG_STAT, s1);
        check_true(s1[0], "status busy bit is low during a copy");
        check_true(s1[16:1] <= 16'd12, "remaining count exceeds the programmed count");
        write_word(DMA_BASE + DMA_REG_CTRL, 32'd100, 4'hf);
        read_word(DMA_BASE + DMA_REG_STAT, s2);
        check_true(s2[16:1] <= s1[16:1], "control write during a copy changed the count");
        wait_dma_idle(12);
        verify_words(700, 12);
        read_word(DMA_BASE + DMA_REG_STAT, rdata);
        check_value(32'h0, rdata);
        end_test();

        $display("Summary: %0d tests passed, %0d tests failed", tests_ok, tests_bad);
        if (errors == 0 && tests_bad == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYC) @(posedge clk);
        $display("Timeout: the run did not end within %0d cycles", WATCHDOG_CYC);
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire

// ==== hw/wb_dma_subsystem.sv ====
// Wishbone memory and DMA subsystem
`timescale 1ns/1ps
`default_nettype none

module wb_dma_subsystem #(
    parameter int unsigned MEM_WORDS = 4096,
    parameter int unsigned LEN_W     = 16
) (
    input  wire                     clk,
    input  wire                     rst,
    input  wire                     wbs_stb_i,
    input  wire                     wbs_cyc_i,
    input  wire                     wbs_we_i,
    input  wire wb_bus_pkg::sel_t   wbs_sel_i,
    input  wire wb_bus_pkg::addr_t  wbs_adr_i,
    input  wire wb_bus_pkg::data_t  wbs_dat_i,
    output logic                    wbs_ack_o,
    output wb_bus_pkg::data_t       wbs_dat_o,
    output logic                    dma_busy_o
);

    // CPU to arbiter, CPU to DMA registers, DMA to arbiter, arbiter to memory
    wb_req_if cpu_mem ();
    wb_req_if dma_reg ();
    wb_req_if dma_mem ();
    wb_req_if sram_bus ();

    wb_addr_decode #(
        .MEM_WORDS (MEM_WORDS)
    ) u_decode (
        .clk       (clk),
        .rst       (rst),
        .wbs_stb_i (wbs_stb_i),
        .wbs_cyc_i (wbs_cyc_i),
        .wbs_we_i  (wbs_we_i),
        .wbs_sel_i (wbs_sel_i),
        .wbs_adr_i (wbs_adr_i),
        .wbs_dat_i (wbs_dat_i),
        .wbs_ack_o (wbs_ack_o),
        .wbs_dat_o (wbs_dat_o),
        .mem_o     (cpu_mem),
        .dma_o     (dma_reg)
    );

    dma_copy_engine #(
        .LEN_W (LEN_W)
    ) u_dma (
        .clk    (clk),
        .rst    (rst),
        .reg_i  (dma_reg),
        .mem_o  (dma_mem),
        .busy_o (dma_busy_o)
    );

    mem_arbiter u_arbiter (
        .clk   (clk),
        .rst   (rst),
        .cpu_i (cpu_mem),
        .dma_i (dma_mem),
        .mem_o (sram_bus)
    );

    wb_sram #(
        .MEM_WORDS (MEM_WORDS)
    ) u_sram (
        .clk   (clk),
        .rst   (rst),
        .bus_i (sram_bus)
    );

endmodule

`default_nettype wire

// ==== hw/wb_sram.sv ====
// Word memory with byte enables
`timescale 1ns/1ps
`default_nettype none

module wb_sram #(
    parameter int unsigned MEM_WORDS = 4096
) (
    input  wire          clk,
    input  wire          rst,
    wb_req_if.responder  bus_i
);

    import wb_bus_pkg::*;

    localparam int unsigned IDX_W = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;

    data_t            mem [MEM_WORDS];
    logic [IDX_W-1:0] idx;
    logic             access;
    logic             ack_q;
    data_t            rdat_q;

    // Word index wraps at the array depth
    assign idx    = IDX_W'(bus_i.adr[ADDR_W-1:2] % MEM_WORDS);
    assign access = bus_i.stb && bus_i.cyc && !ack_q;

    always_ff @(posedge clk) begin
        if (access && bus_i.we) begin
            for (int b = 0; b < SEL_W; b++) begin
                if (bus_i.sel[b]) begin
                    mem[idx][8*b +: 8] <= bus_i.wdat[8*b +: 8];
                end
            end
        end
        if (access) begin
            rdat_q <= mem[idx];
        end
    end

    // No back-to-back ack, each request gets one pulse
    always_ff @(posedge clk) begin
        if (rst) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= access;
        end
    end

    assign bus_i.ack  = ack_q;
    assign bus_i.rdat = rdat_q;

endmodule

`default_nettype wire

// ==== hw/mem_arbiter.sv ====
// Fixed-priority memory arbiter
`timescale 1ns/1ps
`default_nettype none

module mem_arbiter (
    input  wire          clk,
    input  wire          rst,
    wb_req_if.responder  cpu_i,
    wb_req_if.responder  dma_i,
    wb_req_if.requester  mem_o
);

    import wb_bus_pkg::*;

    owner_e owner_q;
    owner_e owner_d;

    // DMA wins a tie, grant holds until the memory acks
    always_comb begin
        owner_d = owner_q;
        case (owner_q)
            OWN_NONE: begin
                if (dma_i.stb && dma_i.cyc) begin
                    owner_d = OWN_DMA;
                end else if (cpu_i.stb && cpu_i.cyc) begin
                    owner_d = OWN_CPU;
                end
            end
            default: begin
                if (mem_o.ack) begin
                    owner_d = OWN_NONE;
                end
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            owner_q <= OWN_NONE;
        end else begin
            owner_q <= owner_d;
        end
    end

    // Only the owner reaches the memory
    always_comb begin
        mem_o.stb  = 1'b0;
        mem_o.cyc  = 1'b0;
        mem_o.we   = 1'b0;
        mem_o.sel  = '0;
        mem_o.adr  = '0;
        mem_o.wdat = '0;
        case (owner_q)
            OWN_DMA: begin
                mem_o.stb  = dma_i.stb;
                mem_o.cyc  = dma_i.cyc;
                mem_o.we   = dma_i.we;
                mem_o.sel  = dma_i.sel;
                mem_o.adr  = dma_i.adr;
                mem_o.wdat = dma_i.wdat;
            end
            OWN_CPU: begin
                mem_o.stb  = cpu_i.stb;
                mem_o.cyc  = cpu_i.cyc;
                mem_o.we   = cpu_i.we;
                mem_o.sel  = cpu_i.sel;
                mem_o.adr  = cpu_i.adr;
                mem_o.wdat = cpu_i.wdat;
            end
            default: ;
        endcase
    end

    // The waiting side sees ack low
    assign dma_i.ack  = (owner_q == OWN_DMA) && mem_o.ack;
    assign dma_i.rdat = (owner_q == OWN_DMA) ? mem_o.rdat : '0;
    assign cpu_i.ack  = (owner_q == OWN_CPU) && mem_o.ack;
    assign cpu_i.rdat = (owner_q == OWN_CPU) ? mem_o.rdat : '0;

endmodule

`default_nettype wire

// ==== hw/dma_copy_engine.sv ====
// Memory-to-memory DMA copy engine
`timescale 1ns/1ps
`default_nettype none

module dma_copy_engine #(
    parameter int unsigned LEN_W = 16
) (
    input  wire          clk,
    input  wire          rst,
    wb_req_if.responder  reg_i,
    wb_req_if.requester  mem_o,
    output logic         busy_o
);

    import wb_bus_pkg::*;
    import soc_map_pkg::*;

    dma_state_e       state;
    logic             req_q;
    logic [LEN_W-1:0] remain_q;
    logic [LEN_W-1:0] ctrl_count;
    logic             busy;
    logic             reg_hit;
    logic             reg_ack_q;
    data_t            reg_rdat_q;
    logic             start;
    addr_t            src_q;
    addr_t            dst_q;
    addr_t            cur_src;
    addr_t            cur_dst;
    data_t            data_q;

    assign busy       = (state != DMA_IDLE);
    assign busy_o     = busy;
    assign reg_hit    = reg_i.stb && reg_i.cyc && !reg_ack_q;
    assign ctrl_count = reg_i.wdat[LEN_W-1:0];

    // A control write with a zero count or during a copy does nothing
    assign start = reg_hit && reg_i.we && (reg_i.adr[3:0] == DMA_REG_CTRL[3:0])
                   && (ctrl_count != '0) && !busy;

    // Register port, ack one cycle after the strobe
    always_ff @(posedge clk) begin
        if (rst) begin
            reg_ack_q <= 1'b0;
            src_q     <= '0;
            dst_q     <= '0;
        end else begin
            reg_ack_q <= reg_hit;
            if (reg_hit && reg_i.we) begin
                case (reg_i.adr[3:0])
                    DMA_REG_SRC[3:0]: src_q <= reg_i.wdat;
                    DMA_REG_DST[3:0]: dst_q <= reg_i.wdat;
                    default: ;
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reg_hit) begin
            case (reg_i.adr[3:0])
                DMA_REG_SRC[3:0]:  reg_rdat_q <= src_q;
                DMA_REG_DST[3:0]:  reg_rdat_q <= dst_q;
                DMA_REG_STAT[3:0]: reg_rdat_q <= DATA_W'({remain_q, busy});
                default:           reg_rdat_q <= '0;
            endcase
        end
    end

    assign reg_i.ack  = reg_ack_q;
    assign reg_i.rdat = reg_rdat_q;

    // Copy sequence: read, idle cycle, write, gap
    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= DMA_IDLE;
            req_q    <= 1'b0;
            remain_q <= '0;
        end else begin
            case (state)
                DMA_IDLE: begin
                    if (start) begin
                        state    <= DMA_READ;
                        req_q    <= 1'b1;
                        remain_q <= ctrl_count;
                    end
                end
                DMA_READ: begin
                    if (mem_o.ack) begin
                        req_q <= 1'b0;
                        state <= DMA_WRITE;
                    end
                end
                DMA_WRITE: begin
                    // Strobe stays low for one cycle after the read ack
                    if (!req_q) begin
                        req_q <= 1'b1;
                    end else if (mem_o.ack) begin
                        req_q    <= 1'b0;
                        remain_q <= remain_q - 1'b1;
                        state    <= DMA_GAP;
                    end
                end
                default: begin
                    // Gap cycle lets a waiting CPU in
                    if (remain_q == '0) begin
                        state <= DMA_IDLE;
                    end else begin
                        state <= DMA_READ;
                        req_q <= 1'b1;
                    end
                end
            endcase
        end
    end

    // Working addresses and the word in flight
    always_ff @(posedge clk) begin
        if (start) begin
            cur_src <= src_q;
            cur_dst <= dst_q;
        end
        if (state == DMA_READ && mem_o.ack) begin
            data_q <= mem_o.rdat;
        end
        if (state == DMA_WRITE && req_q && mem_o.ack) begin
            cur_src <= cur_src + 32'd4;
            cur_dst <= cur_dst + 32'd4;
        end
    end

    assign mem_o.stb  = req_q;
    assign mem_o.cyc  = req_q;
    assign mem_o.we   = (state == DMA_WRITE);
    assign mem_o.sel  = '1;
    assign mem_o.adr  = (state == DMA_WRITE) ? cur_dst : cur_src;
    assign mem_o.wdat = data_q;

endmodule

`default_nettype wire

// ==== hw/wb_addr_decode.sv ====
// CPU address decoder
`timescale 1ns/1ps
`default_nettype none

module wb_addr_decode #(
    parameter int unsigned MEM_WORDS = 4096
) (
    input  wire                     clk,
    input  wire                     rst,
    input  wire                     wbs_stb_i,
    input  wire                     wbs_cyc_i,
    input  wire                     wbs_we_i,
    input  wire wb_bus_pkg::sel_t   wbs_sel_i,
    input  wire wb_bus_pkg::addr_t  wbs_adr_i,
    input  wire wb_bus_pkg::data_t  wbs_dat_i,
    output logic                    wbs_ack_o,
    output wb_bus_pkg::data_t       wbs_dat_o,
    wb_req_if.requester             mem_o,
    wb_req_if.requester             dma_o
);

    import wb_bus_pkg::*;
    import soc_map_pkg::*;

    // Memory window ends at the smaller of the map span and the array size
    localparam addr_t MEM_LIMIT = (MEM_WORDS * 4 < MEM_SPAN) ? addr_t'(MEM_WORDS * 4) : MEM_SPAN;

    region_e region;
    logic    to_mem;
    logic    to_dma;
    logic    none_ack;

    always_comb begin
        if (wbs_adr_i >= MEM_BASE && wbs_adr_i < MEM_BASE + MEM_LIMIT) begin
            region = REGION_MEM;
        end else if (wbs_adr_i[ADDR_W-1:4] == DMA_BASE[ADDR_W-1:4]) begin
            region = REGION_DMA;
        end else begin
            region = REGION_NONE;
        end
    end

    assign to_mem = (region == REGION_MEM);
    assign to_dma = (region == REGION_DMA);

    // Only the selected channel sees a request, the other gets zeros
    assign mem_o.stb  = wbs_stb_i & to_mem;
    assign mem_o.cyc  = wbs_cyc_i & to_mem;
    assign mem_o.we   = wbs_we_i & to_mem;
    assign mem_o.sel  = wbs_sel_i & {SEL_W{to_mem}};
    assign mem_o.adr  = wbs_adr_i & {ADDR_W{to_mem}};
    assign mem_o.wdat = wbs_dat_i & {DATA_W{to_mem}};

    assign dma_o.stb  = wbs_stb_i & to_dma;
    assign dma_o.cyc  = wbs_cyc_i & to_dma;
    assign dma_o.we   = wbs_we_i & to_dma;
    assign dma_o.sel  = wbs_sel_i & {SEL_W{to_dma}};
    assign dma_o.adr  = wbs_adr_i & {ADDR_W{to_dma}};
    assign dma_o.wdat = wbs_dat_i & {DATA_W{to_dma}};

    // Stray accesses finish one cycle after the strobe
    always_ff @(posedge clk) begin
        if (rst) begin
            none_ack <= 1'b0;
        end else begin
            none_ack <= wbs_stb_i && wbs_cyc_i && (region == REGION_NONE) && !none_ack;
        end
    end

    always_comb begin
        case (region)
            REGION_MEM: begin
                wbs_ack_o = mem_o.ack;
                wbs_dat_o = mem_o.rdat;
            end
            REGION_DMA: begin
                wbs_ack_o = dma_o.ack;
                wbs_dat_o = dma_o.rdat;
            end
            default: begin
                wbs_ack_o = none_ack;
                wbs_dat_o = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== hw/wb_req_if.sv ====
// Wishbone request channel
`timescale 1ns/1ps
`default_nettype none

interface wb_req_if;

    import wb_bus_pkg::*;

    // Request side, held until ack
    logic  stb;
    logic  cyc;
    logic  we;
    sel_t  sel;
    addr_t adr;
    data_t wdat;

    // Response side, ack is a single-cycle pulse
    logic  ack;
    data_t rdat;

    modport requester (
        output stb,
        output cyc,
        output we,
        output sel,
        output adr,
        output wdat,
        input  ack,
        input  rdat
    );

    modport responder (
        input  stb,
        input  cyc,
        input  we,
        input  sel,
        input  adr,
        input  wdat,
        output ack,
        output rdat
    );

endinterface

`default_nettype wire

// ==== hw/soc_map_pkg.sv ====
// SoC address map
`default_nettype none

package soc_map_pkg;

    // On-chip word memory window
    localparam logic [31:0] MEM_BASE = 32'h3800_0000;
    localparam logic [31:0] MEM_SPAN = 32'h0000_4000;

    // DMA register block
    localparam logic [31:0] DMA_BASE     = 32'h3000_0080;
    localparam logic [31:0] DMA_REG_SRC  = 32'h0000_0000;
    localparam logic [31:0] DMA_REG_DST  = 32'h0000_0004;
    localparam logic [31:0] DMA_REG_CTRL = 32'h0000_0008;
    localparam logic [31:0] DMA_REG_STAT = 32'h0000_000C;

    // Target of a CPU access
    typedef enum logic [1:0] {
        REGION_MEM,
        REGION_DMA,
        REGION_NONE
    } region_e;

endpackage

`default_nettype wire

// ==== hw/wb_bus_pkg.sv ====
// Wishbone bus types
`default_nettype none

package wb_bus_pkg;

    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int SEL_W  = 4;

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [DATA_W-1:0] data_t;
    typedef logic [SEL_W-1:0]  sel_t;

    // Who currently holds the memory
    typedef enum logic [1:0] {
        OWN_NONE,
        OWN_DMA,
        OWN_CPU
    } owner_e;

    // Copy engine sequencing
    typedef enum logic [1:0] {
        DMA_IDLE,
        DMA_READ,
        DMA_WRITE,
        DMA_GAP
    } dma_state_e;

endpackage

`default_nettype wire
